//--- icache.f
icache_pkg.sv
cache_line_ram.sv
icache_fill.sv
icache_lookup.sv
cpu_instruction_cache.sv
icache_checker.sv
tb_icache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the instruction cache testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir && \
verilator --binary --timing --assert -f icache.f --top-module tb_icache -o sim_icache && \
./obj_dir/sim_icache 2>&1 | tee "$LOG" || { echo "build or run error"; exit 1; }

grep -q "tests failed" "$LOG" && { echo "simulation FAILED"; exit 1; }
grep -q "^all tests passed$" "$LOG" && { echo "simulation PASSED"; exit 0; } || \
	{ echo "simulation ended without a result"; exit 1; }

//--- tb_icache.sv
// ====================
// Instruction cache testbench.
// Drives the cache with a tagged memory model that
// answers two cycles late and delays some answers,
// then runs the sweep, fill, prefetch, conflict and
// invalidation tests and prints the results.
// ====================

`timescale 1ns/1ps
`default_nettype none

module tb_icache;
	import icache_pkg::*;

	localparam int depth_bits     = 4;	// 16 lines.
	localparam int timeout_cycles = 200;	// limit of every wait loop.

	logic        CLK;
	logic        RSTb;
	word_addr_t  fetch_address;
	logic        invalidate_cache;
	cache_line_t fetch_line;
	logic        cache_miss;
	logic        invalidation_done;
	word_addr_t  memory_address;
	logic        memory_rd_req;
	mem_rsp_t    memory_rsp;

	logic [15:0] pending [$];	// valid bit and address of each sampled request.
	int          errors;	// checks failed so far.
	int          test_mark;	// error count when the current test began.
	int          tests_run;
	int          tests_failed;

	cpu_instruction_cache #(
		.CACHE_DEPTH_BITS(depth_bits)
	) i_dut (
		.CLK              (CLK),
		.RSTb             (RSTb),
		.fetch_address    (fetch_address),
		.invalidate_cache (invalidate_cache),
		.fetch_line       (fetch_line),
		.cache_miss       (cache_miss),
		.invalidation_done(invalidation_done),
		.memory_address   (memory_address),
		.memory_rd_req    (memory_rd_req),
		.memory_rsp       (memory_rsp)
	);

	always #2 CLK = ~CLK;	// 4 ns period.

	// memory model, answers each request two cycles later. An answer that loses
	// arbitration stays at the head of the queue and is tried again next cycle.
	always @(posedge CLK) begin : memory_model
		logic [15:0] due;
		#0.5;
		pending.push_back({memory_rd_req === 1'b1, memory_address});
		memory_rsp <= '0;	// no word this cycle unless one is answered below.
		if (pending.size() > 2) begin
			due = pending[0];
			if (!due[15]) begin
				void'(pending.pop_front());	// idle cycle, nothing to answer.
			end else if (($urandom % 4) != 0) begin
				void'(pending.pop_front());
				memory_rsp <= '{success: 1'b1, addr: due[14:0],
					data: {1'b0, due[14:0]} ^ 16'h5a5a};
			end
		end
	end

	// the line memory should return for a given address.
	function automatic cache_line_t expected_line(input word_addr_t addr);
		cache_line_t line;
		line.addr    = addr;
		line.invalid = 1'b0;
		line.instr   = {1'b0, addr} ^ 16'h5a5a;
		return line;
	endfunction

	task automatic step();
		@(posedge CLK);
		#0.5;	// inputs change and outputs are read here.
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("mismatch %s: expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic ok, input string what);
		assert (ok === 1'b1) else begin
			$display("%s: %s", name, what);
			errors++;
		end
	endtask

	// steps until the cache reports a hit.
	task automatic wait_for_hit(input string name);
		int cnt;
		cnt = 0;
		while (cache_miss !== 1'b0 && cnt < timeout_cycles) begin
			step();
			cnt++;
		end
		check_flag(name, cache_miss === 1'b0, "timed out waiting for a cache hit");
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (errors != test_mark) begin
			tests_failed++;
			$display("%s: FAIL", name);
		end else begin
			$display("%s: ok", name);
		end
		test_mark = errors;
	endtask

	initial begin
		int          cnt;
		int          done_at;
		logic [3:0]  prev_index;
		void'($urandom(32'h2e8f_b292));
		CLK              = 1'b0;
		RSTb             = 1'b0;
		fetch_address    = '0;
		invalidate_cache = 1'b0;
		memory_rsp       = '0;
		errors           = 0;
		test_mark        = 0;
		tests_run        = 0;
		tests_failed     = 0;
		repeat (2) @(posedge CLK);
		#0.5;
		RSTb          = 1'b1;
		fetch_address = 15'h0123;

		// the cycle of reset release counts as cycle 1.
		cnt     = 1;
		done_at = 0;
		while (done_at == 0 && cnt < timeout_cycles) begin
			step();
			cnt++;
			check_flag("reset_sweep", memory_rd_req === 1'b0, "memory request during the sweep");
			if (invalidation_done === 1'b1) begin
				done_at = cnt;
			end else if (cnt >= 7) begin
				check_flag("reset_sweep", cache_miss === 1'b1, "hit reported during the sweep");
			end
		end
		check_flag("reset_sweep", done_at != 0, "timed out waiting for invalidation_done");
		check_value("reset_sweep", 32'd18, done_at);
		step();
		check_flag("reset_sweep", invalidation_done === 1'b0, "done pulse longer than one cycle");
		close_test("reset_sweep");

		fetch_address = 15'h2345;
		step();
		check_flag("miss_then_fill", cache_miss === 1'b1, "new address did not miss");
		wait_for_hit("miss_then_fill");
		check_value("miss_then_fill", expected_line(15'h2345), fetch_line);
		close_test("miss_then_fill");

		fetch_address = 15'h3103;	// block 0x310, index 3.
		step();
		step();	// fill index is loaded one cycle after the new request.
		check_value("prefetch", 32'h3103, memory_address);
		prev_index = memory_address[3:0];
		cnt        = 0;
		while (memory_address[3:0] != 4'hf && cnt < timeout_cycles) begin
			step();
			cnt++;
			check_value("prefetch", 32'h310, memory_address[14:4]);
			check_flag("prefetch", memory_rd_req === 1'b1, "memory request dropped in execute");
			check_flag("prefetch", memory_address[3:0] >= prev_index,
				"prefetch index moved backwards");
			prev_index = memory_address[3:0];
		end
		check_flag("prefetch", memory_address[3:0] == 4'hf,
			"timed out before the prefetch reached index 15");
		cnt = 0;
		while (!(memory_rsp.success && memory_rsp.addr == 15'h310f) && cnt < timeout_cycles) begin
			step();
			cnt++;
		end
		check_flag("prefetch", cnt < timeout_cycles, "timed out waiting for the last word");
		wait_for_hit("prefetch");
		for (int i = 4; i < 16; i++) begin
			fetch_address = 15'h3100 | word_addr_t'(i);
			step();
			check_value("prefetch", 32'd0, cache_miss);
			check_value("prefetch", expected_line(fetch_address), fetch_line);
		end
		close_test("prefetch");

		fetch_address = 15'h7205;	// same index as 0x3105, other block.
		step();
		check_flag("conflict", cache_miss === 1'b1, "conflicting address did not miss");
		check_value("conflict", 32'h720, memory_address[14:4]);
		wait_for_hit("conflict");
		check_value("conflict", expected_line(15'h7205), fetch_line);
		fetch_address = 15'h3105;
		step();
		check_flag("conflict", cache_miss === 1'b1, "evicted word still hit");
		close_test("conflict");

		wait_for_hit("invalidate");	// refills 0x3105 first.
		check_value("invalidate", expected_line(15'h3105), fetch_line);
		invalidate_cache = 1'b1;
		step();
		invalidate_cache = 1'b0;
		cnt = 1;
		while (invalidation_done !== 1'b1 && cnt < timeout_cycles) begin
			step();
			cnt++;
		end
		check_flag("invalidate", invalidation_done === 1'b1, "timed out waiting for the sweep");
		check_value("invalidate", 32'd17, cnt);
		step();
		check_flag("invalidate", invalidation_done === 1'b0, "done pulse longer than one cycle");
		check_flag("invalidate", cache_miss === 1'b1, "address still hit after invalidation");
		fetch_address = 15'h3106;	// move away and back to request the refill.
		step();
		fetch_address = 15'h3105;
		step();
		wait_for_hit("invalidate");
		check_value("invalidate", expected_line(15'h3105), fetch_line);
		close_test("invalidate");

		$display("%0d tests run, %0d failed, %0d checks failed", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- icache_checker.sv
// ====================
// Instruction cache checker.
// Concurrent assertions bound to the cache top level
// for the sweep, the done pulse and hit data.
// ====================

`timescale 1ns/1ps
`default_nettype none

module icache_checker
	import icache_pkg::*;
(
	input logic        CLK,
	input logic        RSTb,
	input logic        memory_rd_req,	// memory request level.
	input logic        invalidation_done,	// end of sweep pulse.
	input logic        cache_miss,	// lookup miss flag.
	input cache_line_t fetch_line,	// line handed to the CPU.
	input word_addr_t  request_address,	// registered fetch address.
	input line_wr_t    line_wr	// write into the line store.
);

	logic swept_once;	// the store has been fully cleared at least once.
	logic sweep_write;	// the fill engine writes a cleared line.

	// only the sweep writes lines with the invalid bit set.
	assign sweep_write = line_wr.wr && line_wr.line.invalid;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			swept_once <= 1'b0;
		end else if (invalidation_done) begin
			swept_once <= 1'b1;	// contents are defined from here on.
		end
	end

	// memory must stay idle while lines are being cleared.
	no_request_in_sweep: assert property (@(posedge CLK) disable iff (!RSTb)
		sweep_write |-> !memory_rd_req)
		else $error("memory request seen during invalidation sweep");

	// the done flag is a single cycle pulse.
	done_single_cycle: assert property (@(posedge CLK) disable iff (!RSTb)
		invalidation_done |=> !invalidation_done)
		else $error("invalidation_done held for two cycles");

	// a hit carries the word memory holds at the registered address.
	hit_data_correct: assert property (@(posedge CLK) disable iff (!RSTb)
		(swept_once && !cache_miss) |->
			(fetch_line.instr == ({1'b0, request_address} ^ 16'h5a5a)))
		else $error("hit returned wrong instruction for %h", request_address);

endmodule

bind cpu_instruction_cache icache_checker i_checker (
	.CLK              (CLK),
	.RSTb             (RSTb),
	.memory_rd_req    (memory_rd_req),
	.invalidation_done(invalidation_done),
	.cache_miss       (cache_miss),
	.fetch_line       (fetch_line),
	.request_address  (request_address),
	.line_wr          (line_wr)
);

`default_nettype wire

//--- cpu_instruction_cache.sv
// ====================
// Direct mapped instruction cache.
// Connects the fill engine, the line store and the
// lookup. The CPU gets the line and a miss flag one
// cycle after the fetch address, memory is read
// through a request level and tagged responses.
// ====================

`timescale 1ns/1ps
`default_nettype none

module cpu_instruction_cache
	import icache_pkg::*;
#(
	parameter int CACHE_DEPTH_BITS = 8	// number of index bits, below 15.
) (
	input  logic        CLK,
	input  logic        RSTb,

	// CPU side.
	input  word_addr_t  fetch_address,	// instruction address to fetch.
	input  logic        invalidate_cache,	// request a full invalidation.
	output cache_line_t fetch_line,	// stored line for the previous address.
	output logic        cache_miss,	// fetch_line is not the requested word.
	output logic        invalidation_done,	// one cycle pulse after a sweep.

	// Memory side.
	output word_addr_t  memory_address,	// word being requested.
	output logic        memory_rd_req,	// request level.
	input  mem_rsp_t    memory_rsp	// tagged response from memory.
);

	word_addr_t                  request_address;	// registered fetch address.
	logic                        new_request;	// fetch address just changed.
	line_wr_t                    line_wr;	// fill writes into the store.
	logic [CACHE_DEPTH_BITS-1:0] rd_index;	// store read index.
	cache_line_t                 read_line;	// store read data.

	icache_fill #(
		.CACHE_DEPTH_BITS(CACHE_DEPTH_BITS)
	) i_fill (
		.CLK              (CLK),
		.RSTb             (RSTb),
		.invalidate_cache (invalidate_cache),
		.invalidation_done(invalidation_done),
		.request_address  (request_address),
		.new_request      (new_request),
		.memory_address   (memory_address),
		.memory_rd_req    (memory_rd_req),
		.memory_rsp       (memory_rsp),
		.line_wr          (line_wr)
	);

	cache_line_ram #(
		.CACHE_DEPTH_BITS(CACHE_DEPTH_BITS)
	) i_line_ram (
		.CLK      (CLK),
		.rd_index (rd_index),
		.read_line(read_line),
		.line_wr  (line_wr)
	);

	icache_lookup #(
		.CACHE_DEPTH_BITS(CACHE_DEPTH_BITS)
	) i_lookup (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.fetch_address  (fetch_address),
		.read_line      (read_line),
		.rd_index       (rd_index),
		.request_address(request_address),
		.new_request    (new_request),
		.fetch_line     (fetch_line),
		.cache_miss     (cache_miss)
	);

endmodule

`default_nettype wire

//--- icache_lookup.sv
// ====================
// Instruction cache lookup.
// Registers the fetch address, flags new requests
// and checks the stored line for a hit.
// ====================

`timescale 1ns/1ps
`default_nettype none

module icache_lookup
	import icache_pkg::*;
#(
	parameter int CACHE_DEPTH_BITS = 8	// number of index bits.
) (
	input  logic                        CLK,
	input  logic                        RSTb,
	input  word_addr_t                  fetch_address,	// address presented by the CPU.
	input  cache_line_t                 read_line,	// line from the store, one cycle late.
	output logic [CACHE_DEPTH_BITS-1:0] rd_index,	// line to read from the store.
	output word_addr_t                  request_address,	// fetch address, registered.
	output logic                        new_request,	// one cycle pulse after an address change.
	output cache_line_t                 fetch_line,	// line returned to the CPU.
	output logic                        cache_miss	// line does not hold the fetch address.
);

	logic addr_changed;	// fetch address differs from the registered one.

	// The store read is registered, so indexing it with the live address lines the
	// data up with the registered address in the following cycle.
	assign rd_index     = fetch_address[CACHE_DEPTH_BITS-1:0];
	assign addr_changed = (fetch_address != request_address);

	// new_request is registered too, so fill sees it together with the new address.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			request_address <= '0;
			new_request     <= 1'b0;
		end else begin
			request_address <= fetch_address;
			new_request     <= addr_changed;	// high for one cycle per change.
		end
	end

	// Hit needs the stored address to match and the line to be valid.
	assign fetch_line = read_line;
	assign cache_miss = (read_line.addr != request_address) || read_line.invalid;

endmodule

`default_nettype wire

//--- icache_fill.sv
// ====================
// Instruction cache fill engine.
// Sweeps all lines invalid after reset or on demand,
// then keeps the memory port busy, redirecting to each
// new fetch and prefetching the rest of its block.
// Every returned word is written into its line.
// ====================

`timescale 1ns/1ps
`default_nettype none

module icache_fill
	import icache_pkg::*;
#(
	parameter int CACHE_DEPTH_BITS = 8	// number of index bits, below 15.
) (
	input  logic       CLK,
	input  logic       RSTb,
	input  logic       invalidate_cache,	// CPU asks for a full sweep.
	output logic       invalidation_done,	// one cycle pulse at the end of a sweep.
	input  word_addr_t request_address,	// registered fetch address from lookup.
	input  logic       new_request,	// high for one cycle after the fetch address moved.
	output word_addr_t memory_address,	// word the memory is asked for.
	output logic       memory_rd_req,	// held high while requesting.
	input  mem_rsp_t   memory_rsp,	// strobe, address and data from memory.
	output line_wr_t   line_wr	// write into the line store.
);

	localparam int addr_msb = $bits(word_addr_t) - 1;	// top bit of a word address.
	localparam logic [CACHE_DEPTH_BITS-1:0] last_index = '1;	// highest line index.

	fill_state_t                 state;	// current state.
	fill_state_t                 state_next;	// state for the next cycle.
	logic [CACHE_DEPTH_BITS-1:0] sweep_index;	// line being invalidated.
	logic [CACHE_DEPTH_BITS-1:0] fill_index;	// index of the word being requested.
	logic [CACHE_DEPTH_BITS-1:0] request_index;	// index part of the fetch address.
	logic                        in_execute;	// normal operation.
	logic                        in_sweep;	// invalidation in progress.

	assign in_execute    = (state == execute);
	assign in_sweep      = (state == invalidate);
	assign request_index = request_address[CACHE_DEPTH_BITS-1:0];

	// Next state.
	always_comb begin
		state_next = state;	// hold by default.
		case (state)
			init: begin
				state_next = invalidate;	// always clear the store after reset.
			end
			invalidate: begin
				if (sweep_index == last_index) begin
					state_next = invalidate_done;	// last line written this cycle.
				end
			end
			invalidate_done: begin
				state_next = execute;
			end
			execute: begin
				if (invalidate_cache) begin
					state_next = invalidate;	// restart the sweep from index 0.
				end
			end
			default: begin
				state_next = init;
			end
		endcase
	end

	// State register and sweep counter.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state       <= init;
			sweep_index <= '0;
		end else begin
			state <= state_next;
			if (in_sweep) begin
				sweep_index <= sweep_index + 1'b1;	// wraps to zero after the last line.
			end else begin
				sweep_index <= '0;	// every sweep starts at index 0.
			end
		end
	end

	// Fill index. A new fetch redirects it, otherwise each returned word moves it
	// one line further until the end of the block, which keeps the port busy.
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			fill_index <= '0;
		end else if (new_request) begin
			fill_index <= request_index;	// service the new fetch first.
		end else if (in_execute && memory_rsp.success && (fill_index != last_index)) begin
			fill_index <= fill_index + 1'b1;	// prefetch the next word.
		end
	end

	// Memory request. The block comes from the fetch, the index from the fill counter.
	assign memory_address    = {request_address[addr_msb:CACHE_DEPTH_BITS], fill_index};
	assign memory_rd_req     = in_execute;	// request continuously in execute.
	assign invalidation_done = (state == invalidate_done);

	// Line write. The sweep writes one cleared line per cycle, execute writes
	// every successful response into the line its address selects.
	always_comb begin
		line_wr = '0;	// no write in init or done.
		case (state)
			invalidate: begin
				line_wr.wr    = 1'b1;
				line_wr.index = word_addr_t'(sweep_index);	// zero extended index.
				line_wr.line  = line_invalidated;
			end
			execute: begin
				line_wr.wr           = memory_rsp.success;	// only when a word arrived.
				line_wr.index        = memory_rsp.addr;	// the store keeps the low bits.
				line_wr.line.addr    = memory_rsp.addr;
				line_wr.line.invalid = 1'b0;
				line_wr.line.instr   = memory_rsp.data;
			end
			default: begin
				line_wr = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- cache_line_ram.sv
// ====================
// Cache line store.
// Simple dual port memory, one write port and one
// registered read port, one line per index.
// ====================

`timescale 1ns/1ps
`default_nettype none

module cache_line_ram
	import icache_pkg::*;
#(
	parameter int CACHE_DEPTH_BITS = 8	// number of index bits.
) (
	input  logic                        CLK,
	input  logic [CACHE_DEPTH_BITS-1:0] rd_index,	// line to read, seen on the next cycle.
	output cache_line_t                 read_line,	// registered read data.
	input  line_wr_t                    line_wr	// write strobe, index and line.
);

	localparam int num_lines = 2 ** CACHE_DEPTH_BITS;	// lines held in the store.

	cache_line_t                 lines [num_lines];	// the line array itself.
	logic [CACHE_DEPTH_BITS-1:0] wr_index;	// low bits of the carried index.

	assign wr_index = line_wr.index[CACHE_DEPTH_BITS-1:0];	// upper bits are ignored here.

	// Write port.
	always_ff @(posedge CLK) begin
		if (line_wr.wr) begin
			lines[wr_index] <= line_wr.line;	// store the new line.
		end
	end

	// Read port. Both ports update on the same edge, so a read of the index
	// being written returns the line as it was before the write.
	always_ff @(posedge CLK) begin
		read_line <= lines[rd_index];	// one cycle read latency.
	end

endmodule

`default_nettype wire

//--- icache_pkg.sv
// ====================
// Instruction cache shared types.
// Address, instruction and line layouts, the memory
// response bundle, the line store write bundle and
// the fill state encoding.
// ====================

`default_nettype none

package icache_pkg;

	typedef logic [14:0] word_addr_t;	// word address, CPU and memory side alike.
	typedef logic [15:0] instr_t;	// one instruction word.

	// One cache line. The full address is kept instead of a tag so that the
	// miss compare needs no slicing, and a cleared line is simply all ones.
	typedef struct packed {
		word_addr_t addr;	// word address held in this line.
		logic       invalid;	// set when the line holds nothing.
		instr_t     instr;	// the cached instruction.
	} cache_line_t;

	// What the memory arbiter hands back each cycle.
	typedef struct packed {
		logic       success;	// this cycle carries a word.
		word_addr_t addr;	// address the word belongs to.
		instr_t     data;	// the word itself.
	} mem_rsp_t;

	// One write into the line store.
	typedef struct packed {
		logic        wr;	// write strobe.
		word_addr_t  index;	// line index, the store uses only the low bits.
		cache_line_t line;	// line contents to store.
	} line_wr_t;

	// Fill engine states, in the order they are visited after reset.
	typedef enum logic [1:0] {
		init            = 2'd0,	// one cycle after reset.
		invalidate      = 2'd1,	// sweeping every line.
		invalidate_done = 2'd2,	// single cycle that flags the end of the sweep.
		execute         = 2'd3	// normal operation with memory requests.
	} fill_state_t;

	// Value written by the sweep. Address all ones and invalid bit set.
	localparam cache_line_t line_invalidated = '1;

endpackage

`default_nettype wire
